// ==== common/axi_wr_pkg.sv ====
/*
 * Shared definitions for the two-port AXI4 write arbiter and multiplexer.
 * Holds the bus widths, the payload types, the response codes and the
 * one-hot grant encoding used by the arbiter and the mux.
 */

`default_nettype none

package axi_wr_pkg;

   // Bus widths for the single-beat write path.
   localparam int addr_width = 32;
   localparam int data_width = 32;
   localparam int id_width   = 4;

   // Byte address of one write transaction.
   typedef logic [addr_width-1:0] axi_addr_t;

   // One write data beat.
   typedef logic [data_width-1:0] axi_data_t;

   // One byte enable per data byte.
   typedef logic [data_width/8-1:0] axi_strb_t;

   // Transaction ID, carried through unchanged from AW to B.
   typedef logic [id_width-1:0] axi_id_t;

   // Two-bit AXI write response.
   typedef logic [1:0] axi_resp_t;

   // Only the two response codes that the write path produces are named.
   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

   // The grant is one-hot, bit 0 for port s0 and bit 1 for port s1.
   // A decoded grant vector can therefore be read straight off the state.
   typedef enum logic [1:0]
   {
      grant_s0 = 2'b01,
      grant_s1 = 2'b10
   } wr_grant_t;

endpackage

`default_nettype wire

// ==== common/axi_wr_if.sv ====
/*
 * One AXI4 write bundle with the AW, W and B channels.
 * The master side drives valids, request payloads and bready; the slave
 * side drives the readies and the B payload.
 */

`timescale 1ns/100ps
`default_nettype none

interface axi_wr_if;

   // Write address channel.
   logic                  awvalid;
   logic                  awready;
   axi_wr_pkg::axi_addr_t awaddr;
   axi_wr_pkg::axi_id_t   awid;

   // Write data channel, always a single beat with wlast high.
   logic                  wvalid;
   logic                  wready;
   axi_wr_pkg::axi_data_t wdata;
   axi_wr_pkg::axi_strb_t wstrb;
   logic                  wlast;

   // Write response channel.
   logic                  bvalid;
   logic                  bready;
   axi_wr_pkg::axi_resp_t bresp;
   axi_wr_pkg::axi_id_t   bid;

   // The requesting side of the bundle.
   modport master
   (
      output awvalid, awaddr, awid,
      output wvalid, wdata, wstrb, wlast,
      output bready,
      input  awready, wready,
      input  bvalid, bresp, bid
   );

   // The responding side of the bundle.
   modport slave
   (
      input  awvalid, awaddr, awid,
      input  wvalid, wdata, wstrb, wlast,
      input  bready,
      output awready, wready,
      output bvalid, bresp, bid
   );

endinterface

`default_nettype wire

// ==== axi_wr_mux/axi_wr_arbiter.sv ====
/*
 * Write arbiter for two upstream AXI4 ports.
 * The owner keeps the bus from its AW until its B handshake, then the
 * grant hands over round-robin to the other port.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_wr_arbiter
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  s0_awvalid,
   input  logic                  s0_bready,
   input  logic                  s1_awvalid,
   input  logic                  s1_bready,
   input  logic                  m_bvalid,
   output axi_wr_pkg::wr_grant_t grant
);

   axi_wr_pkg::wr_grant_t grant_nxt;

   logic s0_sel;
   logic s1_sel;
   logic s0_pending;
   logic s1_pending;
   logic s0_pending_set;
   logic s1_pending_set;
   logic s0_pending_clr;
   logic s1_pending_clr;

   // Decode the one-hot grant into per-port selects.
   assign s0_sel = (grant == axi_wr_pkg::grant_s0);
   assign s1_sel = (grant == axi_wr_pkg::grant_s1);

   // A port starts a write when it owns the bus and raises AWVALID.
   assign s0_pending_set = s0_sel & s0_awvalid;
   assign s1_pending_set = s1_sel & s1_awvalid;

   // The write finishes on the B handshake seen while the port is granted.
   // The downstream bvalid only reaches the granted port, so the select
   // qualifies which flag is cleared.
   assign s0_pending_clr = s0_sel & m_bvalid & s0_bready;
   assign s1_pending_clr = s1_sel & m_bvalid & s1_bready;

   // Next grant.
   // The owner's AWVALID comes first, then its pending write.
   // A completed write passes the bus on, and an idle owner yields to a
   // request from the other port.
   always_comb
   begin
      grant_nxt = grant;
      case (grant)
         axi_wr_pkg::grant_s0:
         begin
            if (s0_awvalid)
               grant_nxt = axi_wr_pkg::grant_s0;
            else if (s0_pending && !s0_pending_clr)
               grant_nxt = axi_wr_pkg::grant_s0;
            else if (s0_pending && s0_pending_clr)
               grant_nxt = axi_wr_pkg::grant_s1;
            else if (s1_awvalid)
               grant_nxt = axi_wr_pkg::grant_s1;
         end
         axi_wr_pkg::grant_s1:
         begin
            if (s1_awvalid)
               grant_nxt = axi_wr_pkg::grant_s1;
            else if (s1_pending && !s1_pending_clr)
               grant_nxt = axi_wr_pkg::grant_s1;
            else if (s1_pending && s1_pending_clr)
               grant_nxt = axi_wr_pkg::grant_s0;
            else if (s0_awvalid)
               grant_nxt = axi_wr_pkg::grant_s0;
         end
         // An illegal encoding falls back to port s0.
         default:
            grant_nxt = axi_wr_pkg::grant_s0;
      endcase
   end

   // Grant state and pending flags.
   // A set in the same cycle as a clear wins, so a new write from the owner
   // keeps the bus locked.
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         grant      <= axi_wr_pkg::grant_s0;
         s0_pending <= 1'b0;
         s1_pending <= 1'b0;
      end
      else
      begin
         grant      <= grant_nxt;
         s0_pending <= s0_pending_set | (s0_pending & ~s0_pending_clr);
         s1_pending <= s1_pending_set | (s1_pending & ~s1_pending_clr);
      end
   end

endmodule

`default_nettype wire

// ==== axi_wr_mux/axi_wr_mux.sv ====
/*
 * Write-path multiplexer for two upstream AXI4 bundles.
 * Steers the granted port's AW and W onto the downstream bundle and
 * returns readies and the B channel to that port only.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_wr_mux
(
   input  axi_wr_pkg::wr_grant_t grant,
   axi_wr_if.slave               up0,
   axi_wr_if.slave               up1,
   axi_wr_if.master              down
);

   logic sel0;
   logic sel1;

   // The grant is one-hot, so each bit selects one port.
   assign sel0 = grant[0];
   assign sel1 = grant[1];

   // Request side.
   // Only the granted port's AW and W reach downstream; with neither bit
   // set the valids stay low.
   assign down.awvalid = (sel0 & up0.awvalid) | (sel1 & up1.awvalid);
   assign down.awaddr  = sel1 ? up1.awaddr : up0.awaddr;
   assign down.awid    = sel1 ? up1.awid : up0.awid;

   assign down.wvalid  = (sel0 & up0.wvalid) | (sel1 & up1.wvalid);
   assign down.wdata   = sel1 ? up1.wdata : up0.wdata;
   assign down.wstrb   = sel1 ? up1.wstrb : up0.wstrb;
   assign down.wlast   = sel1 ? up1.wlast : up0.wlast;

   // The granted port decides when the response is taken.
   assign down.bready  = (sel0 & up0.bready) | (sel1 & up1.bready);

   // Ready signals go back to the owner only.
   // The waiting port sees them low and holds its request.
   assign up0.awready  = sel0 & down.awready;
   assign up0.wready   = sel0 & down.wready;
   assign up1.awready  = sel1 & down.awready;
   assign up1.wready   = sel1 & down.wready;

   // Response side.
   // The other port sees bvalid low and a zero payload.
   assign up0.bvalid   = sel0 & down.bvalid;
   assign up0.bresp    = sel0 ? down.bresp : axi_wr_pkg::resp_okay;
   assign up0.bid      = sel0 ? down.bid : '0;

   assign up1.bvalid   = sel1 & down.bvalid;
   assign up1.bresp    = sel1 ? down.bresp : axi_wr_pkg::resp_okay;
   assign up1.bid      = sel1 ? down.bid : '0;

endmodule

`default_nettype wire

// ==== logic/axi_wr_xbar_top.sv ====
/*
 * Top level of the two-port AXI4 write arbiter and multiplexer.
 * Maps the plain s0, s1 and m ports onto write bundles and connects the
 * arbiter and the mux.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_wr_xbar_top
(
   input  logic                  clk,
   input  logic                  rst_n,

   // Upstream port s0.
   input  logic                  s0_awvalid,
   output logic                  s0_awready,
   input  axi_wr_pkg::axi_addr_t s0_awaddr,
   input  axi_wr_pkg::axi_id_t   s0_awid,
   input  logic                  s0_wvalid,
   output logic                  s0_wready,
   input  axi_wr_pkg::axi_data_t s0_wdata,
   input  axi_wr_pkg::axi_strb_t s0_wstrb,
   input  logic                  s0_wlast,
   output logic                  s0_bvalid,
   input  logic                  s0_bready,
   output axi_wr_pkg::axi_resp_t s0_bresp,
   output axi_wr_pkg::axi_id_t   s0_bid,

   // Upstream port s1.
   input  logic                  s1_awvalid,
   output logic                  s1_awready,
   input  axi_wr_pkg::axi_addr_t s1_awaddr,
   input  axi_wr_pkg::axi_id_t   s1_awid,
   input  logic                  s1_wvalid,
   output logic                  s1_wready,
   input  axi_wr_pkg::axi_data_t s1_wdata,
   input  axi_wr_pkg::axi_strb_t s1_wstrb,
   input  logic                  s1_wlast,
   output logic                  s1_bvalid,
   input  logic                  s1_bready,
   output axi_wr_pkg::axi_resp_t s1_bresp,
   output axi_wr_pkg::axi_id_t   s1_bid,

   // Downstream port toward the shared slave.
   output logic                  m_awvalid,
   input  logic                  m_awready,
   output axi_wr_pkg::axi_addr_t m_awaddr,
   output axi_wr_pkg::axi_id_t   m_awid,
   output logic                  m_wvalid,
   input  logic                  m_wready,
   output axi_wr_pkg::axi_data_t m_wdata,
   output axi_wr_pkg::axi_strb_t m_wstrb,
   output logic                  m_wlast,
   input  logic                  m_bvalid,
   output logic                  m_bready,
   input  axi_wr_pkg::axi_resp_t m_bresp,
   input  axi_wr_pkg::axi_id_t   m_bid
);

   axi_wr_pkg::wr_grant_t grant;

   axi_wr_if up0 ();
   axi_wr_if up1 ();
   axi_wr_if down ();

   // Port s0 into its bundle.
   assign up0.awvalid = s0_awvalid;
   assign up0.awaddr  = s0_awaddr;
   assign up0.awid    = s0_awid;
   assign up0.wvalid  = s0_wvalid;
   assign up0.wdata   = s0_wdata;
   assign up0.wstrb   = s0_wstrb;
   assign up0.wlast   = s0_wlast;
   assign up0.bready  = s0_bready;
   assign s0_awready  = up0.awready;
   assign s0_wready   = up0.wready;
   assign s0_bvalid   = up0.bvalid;
   assign s0_bresp    = up0.bresp;
   assign s0_bid      = up0.bid;

   // Port s1 into its bundle.
   assign up1.awvalid = s1_awvalid;
   assign up1.awaddr  = s1_awaddr;
   assign up1.awid    = s1_awid;
   assign up1.wvalid  = s1_wvalid;
   assign up1.wdata   = s1_wdata;
   assign up1.wstrb   = s1_wstrb;
   assign up1.wlast   = s1_wlast;
   assign up1.bready  = s1_bready;
   assign s1_awready  = up1.awready;
   assign s1_wready   = up1.wready;
   assign s1_bvalid   = up1.bvalid;
   assign s1_bresp    = up1.bresp;
   assign s1_bid      = up1.bid;

   // Downstream bundle out to the m ports.
   assign m_awvalid      = down.awvalid;
   assign m_awaddr       = down.awaddr;
   assign m_awid         = down.awid;
   assign m_wvalid       = down.wvalid;
   assign m_wdata        = down.wdata;
   assign m_wstrb        = down.wstrb;
   assign m_wlast        = down.wlast;
   assign m_bready       = down.bready;
   assign down.awready   = m_awready;
   assign down.wready    = m_wready;
   assign down.bvalid    = m_bvalid;
   assign down.bresp     = m_bresp;
   assign down.bid       = m_bid;

   // The arbiter watches the raw requests and the downstream response.
   axi_wr_arbiter axi_wr_arbiter_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .s0_awvalid (s0_awvalid),
      .s0_bready  (s0_bready),
      .s1_awvalid (s1_awvalid),
      .s1_bready  (s1_bready),
      .m_bvalid   (m_bvalid),
      .grant      (grant)
   );

   // The mux routes all three channels from the current grant.
   axi_wr_mux axi_wr_mux_inst
   (
      .grant (grant),
      .up0   (up0.slave),
      .up1   (up1.slave),
      .down  (down.master)
   );

endmodule

`default_nettype wire

// ==== tb/axi_wr_xbar_tb.sv ====
/*
 * Testbench for the two-port AXI4 write arbiter and multiplexer.
 * Applies a table of single-beat writes from ports s0 and s1 to a
 * downstream slave model and checks payloads, order and responses.
 */

`timescale 1ns/100ps
`default_nettype none

module axi_wr_xbar_tb;

   localparam int clk_period = 20;
   localparam int num_tests  = 10;

   // The slave model answers SLVERR from this address upward.
   localparam axi_wr_pkg::axi_addr_t err_bound = 32'hF000_0000;

   logic clk;
   logic rst_n;

   // Upstream requests. Index 0 is port s0 and index 1 is port s1.
   logic [1:0]            awvalid_q;
   logic [1:0]            wvalid_q;
   logic [1:0]            wlast_q;
   logic [1:0]            bready_q;
   axi_wr_pkg::axi_addr_t awaddr_q [2];
   axi_wr_pkg::axi_id_t   awid_q [2];
   axi_wr_pkg::axi_data_t wdata_q [2];
   axi_wr_pkg::axi_strb_t wstrb_q [2];

   // Upstream responses from the DUT.
   wire [1:0]                  awready_w;
   wire [1:0]                  wready_w;
   wire [1:0]                  bvalid_w;
   wire axi_wr_pkg::axi_resp_t bresp_w [2];
   wire axi_wr_pkg::axi_id_t   bid_w [2];

   // Downstream bundle. The readies and the B channel come from the slave model.
   wire                        m_awvalid;
   wire axi_wr_pkg::axi_addr_t m_awaddr;
   wire axi_wr_pkg::axi_id_t   m_awid;
   wire                        m_wvalid;
   wire axi_wr_pkg::axi_data_t m_wdata;
   wire axi_wr_pkg::axi_strb_t m_wstrb;
   wire                        m_wlast;
   wire                        m_bready;
   logic                       m_awready;
   logic                       m_wready;
   logic                       m_bvalid;
   axi_wr_pkg::axi_resp_t      m_bresp;
   axi_wr_pkg::axi_id_t        m_bid;

   // Transaction table with one row per test.
   string                 tbl_name [num_tests];
   logic [1:0]            tbl_en [num_tests];
   int                    tbl_delay [num_tests];
   axi_wr_pkg::axi_addr_t tbl_addr [num_tests][2];
   axi_wr_pkg::axi_data_t tbl_data [num_tests][2];
   axi_wr_pkg::axi_id_t   tbl_id [num_tests][2];
   axi_wr_pkg::axi_strb_t tbl_strb [num_tests][2];

   // A port has a write outstanding from its AW handshake until its B handshake.
   logic [1:0] b_wait;
   string      cur_name;
   int         errors;
   int         row_errors;
   int         passed;
   int         seed;

   axi_wr_xbar_top axi_wr_xbar_top_inst
   (
      .clk        (clk),
      .rst_n      (rst_n),
      .s0_awvalid (awvalid_q[0]),
      .s0_awready (awready_w[0]),
      .s0_awaddr  (awaddr_q[0]),
      .s0_awid    (awid_q[0]),
      .s0_wvalid  (wvalid_q[0]),
      .s0_wready  (wready_w[0]),
      .s0_wdata   (wdata_q[0]),
      .s0_wstrb   (wstrb_q[0]),
      .s0_wlast   (wlast_q[0]),
      .s0_bvalid  (bvalid_w[0]),
      .s0_bready  (bready_q[0]),
      .s0_bresp   (bresp_w[0]),
      .s0_bid     (bid_w[0]),
      .s1_awvalid (awvalid_q[1]),
      .s1_awready (awready_w[1]),
      .s1_awaddr  (awaddr_q[1]),
      .s1_awid    (awid_q[1]),
      .s1_wvalid  (wvalid_q[1]),
      .s1_wready  (wready_w[1]),
      .s1_wdata   (wdata_q[1]),
      .s1_wstrb   (wstrb_q[1]),
      .s1_wlast   (wlast_q[1]),
      .s1_bvalid  (bvalid_w[1]),
      .s1_bready  (bready_q[1]),
      .s1_bresp   (bresp_w[1]),
      .s1_bid     (bid_w[1]),
      .m_awvalid  (m_awvalid),
      .m_awready  (m_awready),
      .m_awaddr   (m_awaddr),
      .m_awid     (m_awid),
      .m_wvalid   (m_wvalid),
      .m_wready   (m_wready),
      .m_wdata    (m_wdata),
      .m_wstrb    (m_wstrb),
      .m_wlast    (m_wlast),
      .m_bvalid   (m_bvalid),
      .m_bready   (m_bready),
      .m_bresp    (m_bresp),
      .m_bid      (m_bid)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic count_error();
      errors     = errors + 1;
      row_errors = row_errors + 1;
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", cur_name, msg);
      count_error();
   endtask

   task automatic check_addr(input string what, input axi_wr_pkg::axi_addr_t exp,
                             input axi_wr_pkg::axi_addr_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_data(input string what, input axi_wr_pkg::axi_data_t exp,
                             input axi_wr_pkg::axi_data_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_strb(input string what, input axi_wr_pkg::axi_strb_t exp,
                             input axi_wr_pkg::axi_strb_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_resp(input string what, input axi_wr_pkg::axi_resp_t exp,
                             input axi_wr_pkg::axi_resp_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
         count_error();
      end
   endtask

   task automatic check_id(input string what, input axi_wr_pkg::axi_id_t exp,
                           input axi_wr_pkg::axi_id_t act);
      if (act !== exp)
      begin
         $display("ERROR %s %s expected %h actual %h", cur_name, what, exp, act);
         count_error();
      end
   endtask

   // Random back-pressure between zero and the row's delay in cycles.
   function automatic int pick_delay(input int idx);
      if (tbl_delay[idx] > 0)
         return $urandom_range(tbl_delay[idx], 0);
      return 0;
   endfunction

   task automatic load_row(input int idx, input string name, input logic [1:0] en,
                           input int delay, input axi_wr_pkg::axi_addr_t a0,
                           input axi_wr_pkg::axi_data_t d0, input axi_wr_pkg::axi_id_t i0,
                           input axi_wr_pkg::axi_strb_t s0, input axi_wr_pkg::axi_addr_t a1,
                           input axi_wr_pkg::axi_data_t d1, input axi_wr_pkg::axi_id_t i1,
                           input axi_wr_pkg::axi_strb_t s1);
      tbl_name[idx]    = name;
      tbl_en[idx]      = en;
      tbl_delay[idx]   = delay;
      tbl_addr[idx][0] = a0;
      tbl_data[idx][0] = d0;
      tbl_id[idx][0]   = i0;
      tbl_strb[idx][0] = s0;
      tbl_addr[idx][1] = a1;
      tbl_data[idx][1] = d1;
      tbl_id[idx][1]   = i1;
      tbl_strb[idx][1] = s1;
   endtask

   // Bit 0 of the enable column is port s0, bit 1 is port s1.
   // Row 3 finds s0 as the idle owner, so s1 has to take the grant over.
   task automatic load_table();
      load_row(0, "s0_lone", 2'b01, 0, 32'h0000_1000, 32'hA5A5_0001, 4'h3, 4'hF,
               32'h0000_0040, 32'h0BAD_0BAD, 4'h1, 4'h1);
      load_row(1, "s1_lone", 2'b10, 0, 32'h0000_0080, 32'h0BAD_0BAD, 4'h2, 4'h1,
               32'h0000_2004, 32'h5A5A_0002, 4'h9, 4'h3);
      load_row(2, "both_s0_owner", 2'b11, 2, 32'h0000_3000, 32'h1111_2222, 4'h4, 4'hF,
               32'h0000_3100, 32'h3333_4444, 4'hC, 4'hC);
      load_row(3, "s1_idle_handover", 2'b10, 1, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0,
               32'h0000_3800, 32'h4444_5555, 4'h7, 4'h6);
      load_row(4, "s0_again", 2'b01, 0, 32'h0000_4008, 32'hDEAD_BEEF, 4'h5, 4'h6,
               32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
      load_row(5, "both_s1_owner", 2'b11, 0, 32'h0000_5000, 32'h0101_0101, 4'h6, 4'h8,
               32'h0000_5004, 32'h0202_0202, 4'hE, 4'hF);
      load_row(6, "backpressure_a", 2'b11, 6, 32'h0000_6000, 32'hCAFE_0001, 4'h7, 4'hF,
               32'h0000_6100, 32'hCAFE_0002, 4'hA, 4'h5);
      load_row(7, "backpressure_b", 2'b11, 9, 32'h0000_7000, 32'hFACE_0003, 4'h8, 4'h3,
               32'h0000_7100, 32'hFACE_0004, 4'hB, 4'hF);
      load_row(8, "s0_slverr", 2'b01, 0, 32'hF000_0010, 32'hEEEE_0005, 4'hD, 4'hF,
               32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
      load_row(9, "s1_after_err", 2'b10, 3, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0,
               32'h0000_8000, 32'h7777_0006, 4'h2, 4'h9);
   endtask

   // One upstream master drives AW and W together, then raises bready after a random delay.
   task automatic run_master(input int p, input int idx);
      bit                    aw_done;
      bit                    w_done;
      bit                    b_done;
      axi_wr_pkg::axi_resp_t exp_resp;
      aw_done  = 1'b0;
      w_done   = 1'b0;
      b_done   = 1'b0;
      exp_resp = axi_wr_pkg::resp_okay;
      if (tbl_addr[idx][p] >= err_bound)
         exp_resp = axi_wr_pkg::resp_slverr;
      @(posedge clk);
      awvalid_q[p] <= 1'b1;
      awaddr_q[p]  <= tbl_addr[idx][p];
      awid_q[p]    <= tbl_id[idx][p];
      wvalid_q[p]  <= 1'b1;
      wdata_q[p]   <= tbl_data[idx][p];
      wstrb_q[p]   <= tbl_strb[idx][p];
      wlast_q[p]   <= 1'b1;
      while (!(aw_done && w_done))
      begin
         @(posedge clk);
         if (!aw_done && awready_w[p])
         begin
            awvalid_q[p] <= 1'b0;
            b_wait[p]    <= 1'b1;
            aw_done = 1'b1;
         end
         if (!w_done && wready_w[p])
         begin
            wvalid_q[p] <= 1'b0;
            wlast_q[p]  <= 1'b0;
            w_done = 1'b1;
         end
      end
      repeat (pick_delay(idx)) @(posedge clk);
      bready_q[p] <= 1'b1;
      while (!b_done)
      begin
         @(posedge clk);
         if (bvalid_w[p] && bready_q[p])
         begin
            check_resp("bresp", exp_resp, bresp_w[p]);
            check_id("bid", tbl_id[idx][p], bid_w[p]);
            bready_q[p] <= 1'b0;
            b_wait[p]   <= 1'b0;
            b_done = 1'b1;
         end
      end
   endtask

   // Downstream slave model.
   // Writes arrive one at a time in the expected port order.
   task automatic serve_slave(input int idx, input int first_p, input int count);
      int                    p;
      bit                    aw_done;
      bit                    w_done;
      bit                    b_done;
      axi_wr_pkg::axi_addr_t got_addr;
      axi_wr_pkg::axi_id_t   got_id;
      for (int k = 0; k < count; k++)
      begin
         p       = (k == 0) ? first_p : 1 - first_p;
         aw_done = 1'b0;
         w_done  = 1'b0;
         b_done  = 1'b0;
         repeat (pick_delay(idx)) @(posedge clk);
         m_awready <= 1'b1;
         m_wready  <= 1'b1;
         while (!(aw_done && w_done))
         begin
            @(posedge clk);
            if (aw_done && m_awvalid)
               report_failure("a second AW reached downstream before the B handshake");
            if (!aw_done && m_awvalid && m_awready)
            begin
               check_addr("awaddr", tbl_addr[idx][p], m_awaddr);
               check_id("awid", tbl_id[idx][p], m_awid);
               got_addr = m_awaddr;
               got_id   = m_awid;
               m_awready <= 1'b0;
               aw_done = 1'b1;
            end
            if (!w_done && m_wvalid && m_wready)
            begin
               check_data("wdata", tbl_data[idx][p], m_wdata);
               check_strb("wstrb", tbl_strb[idx][p], m_wstrb);
               if (!m_wlast)
                  report_failure("wlast was low on a single-beat write");
               m_wready <= 1'b0;
               w_done = 1'b1;
            end
         end
         m_bvalid <= 1'b1;
         m_bresp  <= (got_addr >= err_bound) ? axi_wr_pkg::resp_slverr : axi_wr_pkg::resp_okay;
         m_bid    <= got_id;
         while (!b_done)
         begin
            @(posedge clk);
            if (m_awvalid)
               report_failure("a second AW reached downstream before the B handshake");
            if (m_bvalid && m_bready)
            begin
               m_bvalid <= 1'b0;
               b_done = 1'b1;
            end
         end
      end
   endtask

   // Only the granted port may see readies, and bvalid only with a write outstanding.
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (awready_w == 2'b11 || wready_w == 2'b11 || bvalid_w == 2'b11)
            report_failure("both upstream ports saw a ready or bvalid at once");
         if (bvalid_w[0] && !b_wait[0])
            report_failure("port s0 saw bvalid with no write outstanding");
         if (bvalid_w[1] && !b_wait[1])
            report_failure("port s1 saw bvalid with no write outstanding");
      end
   end

   // Each row gets a budget of 200 cycles.
   initial
   begin
      #(num_tests * 200 * clk_period);
      $display("watchdog expired after %0d cycles, the DUT stopped responding",
               num_tests * 200);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      int first_p;
      int count;
      int last_p;
      int owner;
      seed      = $urandom(56);
      clk       = 1'b0;
      rst_n     = 1'b0;
      awvalid_q = '0;
      wvalid_q  = '0;
      wlast_q   = '0;
      bready_q  = '0;
      b_wait    = '0;
      for (int p = 0; p < 2; p++)
      begin
         awaddr_q[p] = '0;
         awid_q[p]   = '0;
         wdata_q[p]  = '0;
         wstrb_q[p]  = '0;
      end
      m_awready  = 1'b0;
      m_wready   = 1'b0;
      m_bvalid   = 1'b0;
      m_bresp    = axi_wr_pkg::resp_okay;
      m_bid      = '0;
      errors     = 0;
      row_errors = 0;
      passed     = 0;
      owner      = 0;
      cur_name   = "reset";
      load_table();
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < num_tests; i++)
      begin
         cur_name   = tbl_name[i];
         row_errors = 0;
         count      = tbl_en[i][0] + tbl_en[i][1];
         // With both ports requesting, the current owner goes first.
         if (count == 2)
            first_p = owner;
         else if (tbl_en[i][0])
            first_p = 0;
         else
            first_p = 1;
         fork
            if (tbl_en[i][0])
               run_master(0, i);
            if (tbl_en[i][1])
               run_master(1, i);
            serve_slave(i, first_p, count);
         join
         // The grant hands over from the port that finished last.
         last_p = (count == 2) ? 1 - first_p : first_p;
         owner  = 1 - last_p;
         repeat (3)
         begin
            @(posedge clk);
            if (m_awvalid)
               report_failure("an AW reached downstream after the row's writes completed");
         end
         if (row_errors == 0)
         begin
            $display("test %s: ok", cur_name);
            passed = passed + 1;
         end
         else
            $display("test %s: %0d error(s)", cur_name, row_errors);
      end
      $display("summary: %0d tests, %0d ok, %0d failed, %0d errors",
               num_tests, passed, num_tests - passed, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/axi_wr_pkg.sv
common/axi_wr_if.sv
axi_wr_mux/axi_wr_arbiter.sv
axi_wr_mux/axi_wr_mux.sv
logic/axi_wr_xbar_top.sv
tb/axi_wr_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: axi_wr_xbar

sources:
  - common/axi_wr_pkg.sv
  - common/axi_wr_if.sv
  - axi_wr_mux/axi_wr_arbiter.sv
  - axi_wr_mux/axi_wr_mux.sv
  - logic/axi_wr_xbar_top.sv
  - target: test
    files:
      - tb/axi_wr_xbar_tb.sv
